// File: include/spi_target_defs.svh
`ifndef SPI_TARGET_DEFS_SVH
`define SPI_TARGET_DEFS_SVH

// Constants for the SPI-domain bit counters.
// Both shifters move one byte per frame slot.

// Number of SCK cycles in one byte.
`define SPI_BITS 8

// Index of the last bit in a byte.
// The MSB goes first, so this is also the MSB position.
`define SPI_LAST_BIT 7

`endif

// File: src/spi_target_pkg.sv
package spi_target_pkg;

   // One data byte, on the SPI side and on the bus.
   typedef logic [7:0] byte_t;

   // Request from the target to the byte bus.
   // The target holds stb, we and dat until ack.
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      byte_t dat;
   } bus_req_t;

   // Response from the bus slave.
   // The dat field is only meaningful on a read ack.
   typedef struct packed {
      logic  ack;
      byte_t dat;
   } bus_rsp_t;

   // Sticky error flags, cleared by system reset only.
   typedef struct packed {
      logic overflow;
      logic underrun;
   } spi_status_t;

   // First MISO byte of every frame.
   localparam byte_t HEADER_BYTE = 8'hA7;

   // Entries per FIFO and the matching pointer width.
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage

// File: src/spi_async_fifo.sv
`timescale 1ns/1ps

module spi_async_fifo (
   input  logic                  wr_clk_i,
   input  logic                  wr_en_i,
   input  spi_target_pkg::byte_t wr_data_i,
   input  logic                  rd_clk_i,
   input  logic                  rd_en_i,
   output spi_target_pkg::byte_t rd_data_o,
   input  logic                  rst_i,
   output logic                  empty_o,
   output logic                  full_o
);
   import spi_target_pkg::*;

   // Storage array, written in the write domain only.
   byte_t mem_q [FIFO_DEPTH];

   // Pointers carry one extra wrap bit.
   logic [FIFO_AW:0] wr_bin_q, wr_bin_next, wr_gray_q;
   logic [FIFO_AW:0] rd_bin_q, rd_bin_next, rd_gray_q;

   // Read pointer as seen by the write side.
   logic [FIFO_AW:0] rd_gray_w1_q, rd_gray_w2_q;
   // Write pointer as seen by the read side.
   logic [FIFO_AW:0] wr_gray_r1_q, wr_gray_r2_q;

   logic wr_push, rd_pop;

   // ------------------------------
   // Write domain.
   // ------------------------------

   // A full FIFO ignores the write.
   assign wr_push     = wr_en_i && !full_o;
   assign wr_bin_next = wr_bin_q + 1'b1;

   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_bin_q  <= '0;
         wr_gray_q <= '0;
      end else if (wr_push) begin
         wr_bin_q  <= wr_bin_next;
         wr_gray_q <= wr_bin_next ^ (wr_bin_next >> 1);
      end
   end

   always_ff @(posedge wr_clk_i) begin
      if (wr_push) begin
         mem_q[wr_bin_q[FIFO_AW-1:0]] <= wr_data_i;
      end
   end

   // Two-flop synchroniser for the read pointer.
   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_gray_w1_q <= '0;
         rd_gray_w2_q <= '0;
      end else begin
         rd_gray_w1_q <= rd_gray_q;
         rd_gray_w2_q <= rd_gray_w1_q;
      end
   end

   // Full when the two top Gray bits differ and the rest match.
   assign full_o = (wr_gray_q ==
                    {~rd_gray_w2_q[FIFO_AW:FIFO_AW-1], rd_gray_w2_q[FIFO_AW-2:0]});

   // ------------------------------
   // Read domain.
   // ------------------------------

   assign rd_pop      = rd_en_i && !empty_o;
   assign rd_bin_next = rd_bin_q + 1'b1;

   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_bin_q  <= '0;
         rd_gray_q <= '0;
      end else if (rd_pop) begin
         rd_bin_q  <= rd_bin_next;
         rd_gray_q <= rd_bin_next ^ (rd_bin_next >> 1);
      end
   end

   // Two-flop synchroniser for the write pointer.
   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_gray_r1_q <= '0;
         wr_gray_r2_q <= '0;
      end else begin
         wr_gray_r1_q <= wr_gray_q;
         wr_gray_r2_q <= wr_gray_r1_q;
      end
   end

   assign empty_o = (rd_gray_q == wr_gray_r2_q);

   // Head entry shows before the pop (first-word fall-through).
   assign rd_data_o = mem_q[rd_bin_q[FIFO_AW-1:0]];

   // Producers must look at full before they write.
   a_no_write_full: assert property (@(posedge wr_clk_i) disable iff (rst_i)
      wr_en_i |-> !full_o)
      else $error("write into a full FIFO");

   // Consumers must look at empty before they read.
   a_no_read_empty: assert property (@(posedge rd_clk_i) disable iff (rst_i)
      rd_en_i |-> !empty_o)
      else $error("read from an empty FIFO");

endmodule

// File: src/spi_rx_shifter.sv
`timescale 1ns/1ps
`include "spi_target_defs.svh"

module spi_rx_shifter (
   input  logic                  sck_i,
   input  logic                  cs_n_i,
   input  logic                  mosi_i,
   input  logic                  rst_i,
   input  logic                  fifo_full_i,
   output spi_target_pkg::byte_t byte_o,
   output logic                  byte_valid_o,
   output logic                  prefetch_o,
   output logic                  overflow_o
);
   import spi_target_pkg::*;

   // Bit counter width and last-bit value.
   localparam int CNT_W = $clog2(`SPI_BITS);
   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SPI_LAST_BIT);

   logic             clr;
   logic             byte_done;
   logic [CNT_W-1:0] bit_cnt_q;
   logic             prefetch_q;
   logic             overflow_q;
   byte_t            shift_q;

   // Select high or system reset restarts the byte framing.
   assign clr = cs_n_i | rst_i;

   // ------------------------------
   // Capture on rising SCK.
   // ------------------------------
   always_ff @(posedge sck_i or posedge clr) begin
      if (clr) begin
         bit_cnt_q  <= '0;
         prefetch_q <= 1'b0;
      end else begin
         bit_cnt_q  <= bit_cnt_q + 1'b1;
         // High between the first and second bit of each byte.
         prefetch_q <= (bit_cnt_q == '0);
      end
   end

   // MSB first, so new bits enter at the bottom.
   always_ff @(posedge sck_i) begin
      shift_q <= byte_o;
   end

   // The byte including the bit on the current edge.
   assign byte_o    = {shift_q[`SPI_LAST_BIT-1:0], mosi_i};
   assign byte_done = (bit_cnt_q == LAST_BIT);

   // A full FIFO drops the completed byte.
   assign byte_valid_o = byte_done && !fifo_full_i;
   assign prefetch_o   = prefetch_q;

   // Sticky overflow, cleared only by system reset.
   always_ff @(posedge sck_i or posedge rst_i) begin
      if (rst_i) begin
         overflow_q <= 1'b0;
      end else if (byte_done && fifo_full_i) begin
         overflow_q <= 1'b1;
      end
   end

   assign overflow_o = overflow_q;

endmodule

// File: src/spi_tx_shifter.sv
`timescale 1ns/1ps
`include "spi_target_defs.svh"

module spi_tx_shifter (
   input  logic                  sck_i,
   input  logic                  cs_n_i,
   input  logic                  rst_i,
   input  spi_target_pkg::byte_t fifo_data_i,
   input  logic                  fifo_empty_i,
   output logic                  fifo_rd_o,
   output logic                  miso_o,
   output logic                  underrun_o
);
   import spi_target_pkg::*;

   localparam int CNT_W = $clog2(`SPI_BITS);
   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SPI_LAST_BIT);

   logic             clr;
   logic             busy_q;
   logic [CNT_W-1:0] bit_cnt_q;
   logic             tx_next;
   logic             rd_q;
   logic             underrun_q;
   byte_t            tx_q;

   assign clr     = cs_n_i | rst_i;
   assign tx_next = busy_q && (bit_cnt_q == LAST_BIT);

   // ------------------------------
   // Shift out on falling SCK.
   // ------------------------------

   // Idle until the first falling edge of the frame.
   always_ff @(negedge sck_i or posedge clr) begin
      if (clr) begin
         busy_q    <= 1'b0;
         bit_cnt_q <= '0;
         rd_q      <= 1'b0;
      end else begin
         busy_q    <= 1'b1;
         bit_cnt_q <= bit_cnt_q + 1'b1;
         // Pop one edge after the load, so the head is used first.
         rd_q      <= tx_next && !fifo_empty_i;
      end
   end

   // Header goes out pre-rotated since its MSB is already on the pin.
   // On an empty FIFO the old byte keeps rotating.
   always_ff @(negedge sck_i) begin
      if (!busy_q) begin
         tx_q <= {HEADER_BYTE[`SPI_LAST_BIT-1:0], HEADER_BYTE[`SPI_LAST_BIT]};
      end else if (tx_next && !fifo_empty_i) begin
         tx_q <= fifo_data_i;
      end else begin
         tx_q <= {tx_q[`SPI_LAST_BIT-1:0], tx_q[`SPI_LAST_BIT]};
      end
   end

   // Header MSB shows before the first clock.
   assign miso_o    = busy_q ? tx_q[`SPI_LAST_BIT] : HEADER_BYTE[`SPI_LAST_BIT];
   assign fifo_rd_o = rd_q;

   // Sticky underrun, cleared only by system reset.
   always_ff @(negedge sck_i or posedge rst_i) begin
      if (rst_i) begin
         underrun_q <= 1'b0;
      end else if (tx_next && fifo_empty_i) begin
         underrun_q <= 1'b1;
      end
   end

   assign underrun_o = underrun_q;

   // The strobe raised after a load must still find data in the FIFO.
   a_rd_not_empty: assert property (@(negedge sck_i) disable iff (clr)
      $rose(fifo_rd_o) |-> !fifo_empty_i)
      else $error("transmit read strobe on an empty FIFO");

endmodule

// File: src/spi_bus_master.sv
`timescale 1ns/1ps

module spi_bus_master (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     cs_n_i,
   input  logic                     prefetch_i,
   input  spi_target_pkg::byte_t    rx_data_i,
   input  logic                     rx_empty_i,
   output logic                     rx_rd_o,
   output spi_target_pkg::bus_req_t bus_o,
   input  spi_target_pkg::bus_rsp_t bus_i,
   output logic                     tx_wr_o,
   output logic                     tx_flush_o
);
   import spi_target_pkg::*;

   // Read, wait for the received byte, then write it.
   typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WAIT, ST_SEND} state_e;

   state_e state_q;
   logic   cyc_q, stb_q, we_q;
   byte_t  dat_q;
   logic   cs_meta_q, cs_act_q, cs_prev_q;
   logic   pf_meta_q, pf_sync_q, pf_prev_q;
   logic   pf_edge, pend_q, start;
   logic   flush_q;

   // ------------------------------
   // Synchronisers.
   // ------------------------------
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cs_meta_q <= 1'b0;
         cs_act_q  <= 1'b0;
         cs_prev_q <= 1'b0;
         pf_meta_q <= 1'b0;
         pf_sync_q <= 1'b0;
         pf_prev_q <= 1'b0;
      end else begin
         cs_meta_q <= !cs_n_i;
         cs_act_q  <= cs_meta_q;
         cs_prev_q <= cs_act_q;
         pf_meta_q <= prefetch_i;
         pf_sync_q <= pf_meta_q;
         pf_prev_q <= pf_sync_q;
      end
   end

   assign pf_edge = pf_sync_q && !pf_prev_q;
   assign start   = (state_q == ST_IDLE) && cs_act_q && (pf_edge || pend_q);

   // Holds a request that arrives while a transfer is still running.
   // Flush clears the transmit FIFO once the frame has ended.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         pend_q  <= 1'b0;
         flush_q <= 1'b0;
      end else begin
         pend_q  <= cs_act_q && !start && (pend_q || pf_edge);
         flush_q <= cs_prev_q && !cs_act_q;
      end
   end

   // ------------------------------
   // Bus state machine.
   // ------------------------------
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
         we_q    <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (start) begin
                  state_q <= ST_READ;
                  cyc_q   <= 1'b1;
                  stb_q   <= 1'b1;
                  we_q    <= 1'b0;
               end
            end
            ST_READ: begin
               // Frame ended, so the prefetch is abandoned.
               if (!cs_act_q) begin
                  state_q <= ST_IDLE;
                  cyc_q   <= 1'b0;
                  stb_q   <= 1'b0;
               end else if (bus_i.ack) begin
                  state_q <= ST_WAIT;
                  stb_q   <= 1'b0;
               end
            end
            ST_WAIT: begin
               if (!rx_empty_i) begin
                  state_q <= ST_SEND;
                  stb_q   <= 1'b1;
                  we_q    <= 1'b1;
               end else if (!cs_act_q) begin
                  state_q <= ST_IDLE;
                  cyc_q   <= 1'b0;
               end
            end
            ST_SEND: begin
               // Received data is never dropped, the write completes.
               if (bus_i.ack) begin
                  state_q <= ST_IDLE;
                  cyc_q   <= 1'b0;
                  stb_q   <= 1'b0;
                  we_q    <= 1'b0;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Pop the received byte into the write data on entry to send.
   assign rx_rd_o = (state_q == ST_WAIT) && !rx_empty_i;

   always_ff @(posedge clk_i) begin
      if (rx_rd_o) begin
         dat_q <= rx_data_i;
      end
   end

   assign tx_wr_o    = stb_q && !we_q && bus_i.ack;
   assign tx_flush_o = flush_q;
   assign bus_o      = '{cyc: cyc_q, stb: stb_q, we: we_q, dat: dat_q};

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_q |-> cyc_q)
      else $error("bus strobe outside a cycle");

   a_we_held: assert property (@(posedge clk_i) disable iff (rst_i)
      (stb_q && !bus_i.ack) |=> $stable(we_q))
      else $error("bus direction changed before ack");

endmodule

// File: src/spi_target.sv
`timescale 1ns/1ps

module spi_target (
   input  logic                        clk_i,
   input  logic                        SSEL,
   output spi_target_pkg::bus_req_t    bus_o,
   input  spi_target_pkg::bus_rsp_t    bus_i,
   output spi_target_pkg::spi_status_t status_o,
   input  logic                        spi_sck_i,
   input  logic                        spi_cs_n_i,
   input  logic                        spi_mosi_i,
   output logic                        spi_miso_o
);
   import spi_target_pkg::*;

   byte_t rx_byte, rx_data, tx_data;
   logic  rx_valid, rx_full, rx_empty, rx_rd;
   logic  prefetch, overflow;
   logic  tx_wr, tx_flush, tx_rst, tx_empty, tx_rd;
   logic  underrun, sck_n;

   // Transmit FIFO is read on falling SCK.
   assign sck_n = ~spi_sck_i;

   // Prefetched bytes die with the frame.
   assign tx_rst = SSEL | tx_flush;

   // ------------------------------
   // SPI to bus.
   // ------------------------------
   spi_rx_shifter rx_shift_i (
      .sck_i        (spi_sck_i),
      .cs_n_i       (spi_cs_n_i),
      .mosi_i       (spi_mosi_i),
      .rst_i        (SSEL),
      .fifo_full_i  (rx_full),
      .byte_o       (rx_byte),
      .byte_valid_o (rx_valid),
      .prefetch_o   (prefetch),
      .overflow_o   (overflow)
   );

   spi_async_fifo rx_fifo_i (
      .wr_clk_i  (spi_sck_i),
      .wr_en_i   (rx_valid),
      .wr_data_i (rx_byte),
      .rd_clk_i  (clk_i),
      .rd_en_i   (rx_rd),
      .rd_data_o (rx_data),
      .rst_i     (SSEL),
      .empty_o   (rx_empty),
      .full_o    (rx_full)
   );

   spi_bus_master bus_i0 (
      .clk_i      (clk_i),
      .rst_i      (SSEL),
      .cs_n_i     (spi_cs_n_i),
      .prefetch_i (prefetch),
      .rx_data_i  (rx_data),
      .rx_empty_i (rx_empty),
      .rx_rd_o    (rx_rd),
      .bus_o      (bus_o),
      .bus_i      (bus_i),
      .tx_wr_o    (tx_wr),
      .tx_flush_o (tx_flush)
   );

   // ------------------------------
   // Bus to SPI.
   // ------------------------------
   // At most two bytes are in flight, full is never reached.
   spi_async_fifo tx_fifo_i (
      .wr_clk_i  (clk_i),
      .wr_en_i   (tx_wr),
      .wr_data_i (bus_i.dat),
      .rd_clk_i  (sck_n),
      .rd_en_i   (tx_rd),
      .rd_data_o (tx_data),
      .rst_i     (tx_rst),
      .empty_o   (tx_empty),
      .full_o    ()
   );

   spi_tx_shifter tx_shift_i (
      .sck_i        (spi_sck_i),
      .cs_n_i       (spi_cs_n_i),
      .rst_i        (SSEL),
      .fifo_data_i  (tx_data),
      .fifo_empty_i (tx_empty),
      .fifo_rd_o    (tx_rd),
      .miso_o       (spi_miso_o),
      .underrun_o   (underrun)
   );

   assign status_o = '{overflow: overflow, underrun: underrun};

endmodule

// File: bench/spi_target_tb.sv
`timescale 1ns/1ps

module spi_target_tb;
   import spi_target_pkg::*;

   // Timing of the SPI host, in clk_i cycles per SCK half period.
   localparam int CLK_NS    = 4;
   localparam int HALF_CLKS = 6;
   localparam int MAX_BYTES = 18;
   localparam int N_TESTS   = 5;
   // Longest frame plus select and gap overhead.
   localparam int FRAME_NS   = MAX_BYTES * 8 * 2 * HALF_CLKS * CLK_NS + 200;
   localparam int TIMEOUT_NS = N_TESTS * FRAME_NS * 4;
   // Ack delay long enough to never arrive within a test.
   localparam int unsigned HOLD = 100000;

   logic        clk_i = 1'b0;
   logic        SSEL;
   logic        spi_sck, spi_cs_n, spi_mosi;
   logic        spi_miso;
   bus_req_t    bus_req;
   bus_rsp_t    bus_rsp = '0;
   spi_status_t status;

   int unsigned rd_delay = 0;
   int unsigned wr_delay = 0;
   int unsigned ack_wait = 0;
   logic [31:0] rnd_state = 32'd30;
   logic        watch_stb = 1'b0;
   logic        prev_stb = 1'b0;
   logic        prev_ack = 1'b0;

   // Host bytes, bytes seen on MISO, and the bus traffic log.
   byte_t mosi_bytes[$];
   byte_t miso_bytes[$];
   byte_t rd_log[$];
   byte_t wr_log[$];

   spi_target dut_i (
      .clk_i      (clk_i),
      .SSEL       (SSEL),
      .bus_o      (bus_req),
      .bus_i      (bus_rsp),
      .status_o   (status),
      .spi_sck_i  (spi_sck),
      .spi_cs_n_i (spi_cs_n),
      .spi_mosi_i (spi_mosi),
      .spi_miso_o (spi_miso)
   );

   always #2 clk_i = ~clk_i;

   // xorshift32 step.
   function automatic logic [31:0] next_random(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic expect_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
      if (actual !== expected) begin
         $display("[FAIL] %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
         $display("Some tests failed");
         $fatal(1, "Stopping at the first mismatch.");
      end
   endtask

   // ------------------------------
   // Bus slave model.
   // ------------------------------

   // One-cycle ack after the programmed delay; reads return random bytes.
   always @(posedge clk_i) begin
      if (SSEL) begin
         bus_rsp.ack <= 1'b0;
         ack_wait    <= 0;
      end else begin
         bus_rsp.ack <= 1'b0;
         if (bus_req.stb && !bus_rsp.ack) begin
            if (ack_wait >= (bus_req.we ? wr_delay : rd_delay)) begin
               bus_rsp.ack <= 1'b1;
               ack_wait    <= 0;
               if (!bus_req.we) begin
                  rnd_state   <= next_random(rnd_state);
                  bus_rsp.dat <= byte_t'(next_random(rnd_state));
               end
            end else begin
               ack_wait <= ack_wait + 1;
            end
         end else begin
            ack_wait <= 0;
         end
      end
   end

   // A transfer completes on a cycle with both stb and ack high.
   always @(posedge clk_i) begin
      if (!SSEL && bus_rsp.ack && bus_req.stb) begin
         if (bus_req.we) begin
            wr_log.push_back(bus_req.dat);
         end else begin
            rd_log.push_back(bus_rsp.dat);
         end
      end
   end

   // Strobe must hold until the slave acks.
   always @(posedge clk_i) begin
      if (watch_stb && prev_stb && !prev_ack) begin
         expect_equal(bus_req.stb, 1'b1, "bus strobe dropped before ack");
      end
      prev_stb <= bus_req.stb;
      prev_ack <= bus_rsp.ack;
   end

   // ------------------------------
   // SPI host model.
   // ------------------------------

   // Mode 0 frame; MOSI changes with SCK low, MISO sampled at SCK rise.
   task automatic transfer_frame();
      byte_t miso_byte;
      int    b;
      miso_bytes.delete();
      spi_cs_n <= 1'b0;
      repeat (HALF_CLKS) @(posedge clk_i);
      foreach (mosi_bytes[i]) begin
         for (b = 7; b >= 0; b--) begin
            spi_mosi <= mosi_bytes[i][b];
            repeat (HALF_CLKS) @(posedge clk_i);
            miso_byte[b] = spi_miso;
            spi_sck <= 1'b1;
            repeat (HALF_CLKS) @(posedge clk_i);
            spi_sck <= 1'b0;
         end
         miso_bytes.push_back(miso_byte);
      end
      repeat (4) @(posedge clk_i);
      spi_cs_n <= 1'b1;
      // Gap for select sync and the flush.
      repeat (12) @(posedge clk_i);
   endtask

   task automatic pulse_reset();
      SSEL <= 1'b1;
      repeat (3) @(posedge clk_i);
      SSEL <= 1'b0;
      @(posedge clk_i);
   endtask

   // Header first, then each read response one byte later.
   task automatic compare_traffic(input int nbytes);
      while (wr_log.size() < nbytes) @(posedge clk_i);
      expect_equal(wr_log.size(), nbytes, "number of bus writes");
      expect_equal(rd_log.size(), nbytes, "number of bus reads");
      expect_equal(miso_bytes[0], HEADER_BYTE, "first MISO byte is the header");
      for (int i = 0; i < nbytes; i++) begin
         expect_equal(wr_log[i], mosi_bytes[i], $sformatf("bus write %0d", i));
      end
      for (int i = 1; i < nbytes; i++) begin
         expect_equal(miso_bytes[i], rd_log[i-1], $sformatf("MISO byte %0d", i));
      end
   endtask

   // ------------------------------
   // Tests.
   // ------------------------------

   task automatic check_reset_state();
      expect_equal(bus_req.cyc, 1'b0, "cyc after reset");
      expect_equal(bus_req.stb, 1'b0, "stb after reset");
      expect_equal(bus_req.we, 1'b0, "we after reset");
      expect_equal(status, 2'b00, "status after reset");
      expect_equal(spi_miso, HEADER_BYTE[7], "MISO shows the header MSB");
   endtask

   task automatic run_write_read();
      rd_log.delete();
      wr_log.delete();
      mosi_bytes.delete();
      mosi_bytes.push_back(8'h3C);
      mosi_bytes.push_back(8'h5A);
      mosi_bytes.push_back(8'hC3);
      mosi_bytes.push_back(8'h81);
      transfer_frame();
      compare_traffic(4);
   endtask

   task automatic apply_back_pressure();
      rd_delay  <= 5;
      wr_delay  <= 5;
      watch_stb <= 1'b1;
      rd_log.delete();
      wr_log.delete();
      mosi_bytes.delete();
      mosi_bytes.push_back(8'hE1);
      mosi_bytes.push_back(8'h07);
      mosi_bytes.push_back(8'h96);
      mosi_bytes.push_back(8'h2B);
      transfer_frame();
      compare_traffic(4);
      expect_equal(status, 2'b00, "no flag under back-pressure");
      watch_stb <= 1'b0;
      rd_delay  <= 0;
      wr_delay  <= 0;
   endtask

   task automatic flush_and_underrun();
      mosi_bytes.delete();
      mosi_bytes.push_back(8'h11);
      transfer_frame();
      expect_equal(status.underrun, 1'b0, "no underrun in the short frame");
      // Short frame leaves its prefetched byte behind.
      // Only the flush empties the FIFO before the next boundary.
      rd_delay <= HOLD;
      mosi_bytes.delete();
      mosi_bytes.push_back(8'h22);
      transfer_frame();
      expect_equal(miso_bytes[0], HEADER_BYTE, "header opens the next frame");
      expect_equal(status.underrun, 1'b1, "underrun after a withheld read");
      // Read answered in time, so this frame has no underrun of its own.
      rd_delay <= 0;
      mosi_bytes.delete();
      mosi_bytes.push_back(8'h44);
      transfer_frame();
      expect_equal(status.underrun, 1'b1, "underrun is sticky");
      pulse_reset();
      expect_equal(status.underrun, 1'b0, "underrun cleared by reset");
   endtask

   task automatic force_overflow();
      wr_delay <= HOLD;
      mosi_bytes.delete();
      for (int i = 0; i < MAX_BYTES; i++) begin
         mosi_bytes.push_back(byte_t'(8'h40 + i));
      end
      transfer_frame();
      expect_equal(status.overflow, 1'b1, "overflow with writes withheld");
      pulse_reset();
      expect_equal(status, 2'b00, "flags cleared by reset");
      wr_delay <= 0;
   endtask

   // Stops the run if the tests stall.
   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish in the expected time.");
      $display("Some tests failed");
      $fatal(1, "Simulation stopped by the watchdog.");
   end

   initial begin
      SSEL     = 1'b1;
      spi_sck  = 1'b0;
      spi_cs_n = 1'b1;
      spi_mosi = 1'b0;
      repeat (3) @(posedge clk_i);
      SSEL <= 1'b0;
      @(posedge clk_i);
      check_reset_state();
      run_write_read();
      apply_back_pressure();
      flush_and_underrun();
      force_overflow();
      $display("All tests passed");
      $finish;
   end

endmodule

// File: project.f
+incdir+include
src/spi_target_pkg.sv
src/spi_async_fifo.sv
src/spi_rx_shifter.sv
src/spi_tx_shifter.sv
src/spi_bus_master.sv
src/spi_target.sv
bench/spi_target_tb.sv
